// ==== verilog/rv_trap_defines.svh ====
`ifndef RV_TRAP_DEFINES_SVH
`define RV_TRAP_DEFINES_SVH

// Register and bus data width of the core
`define RV_XLEN 32

// Interrupt bit positions shared by mip and mie
`define RV_MSI_BIT 3
`define RV_MTI_BIT 7
`define RV_MEI_BIT 11

// Enable bits inside mstatus
`define RV_MSTATUS_MIE_BIT 3
`define RV_MSTATUS_MPIE_BIT 7

// Byte offsets of the timer block registers
`define CLINT_MSIP_OFS 8'h00
`define CLINT_MTIMECMP_LO_OFS 8'h08
`define CLINT_MTIMECMP_HI_OFS 8'h0C
`define CLINT_MTIME_LO_OFS 8'h10
`define CLINT_MTIME_HI_OFS 8'h14

// APB address width of the timer block
`define CLINT_ADDR_W 8

`endif

// ==== verilog/rv_csr_pkg.sv ====
package rv_csr_pkg;

  // Machine CSR numbers as they appear in the instruction immediate field
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,  // Global interrupt enable and its saved copy
    CSR_MIE      = 12'h304,  // Per source interrupt enables
    CSR_MTVEC    = 12'h305,  // Trap vector base with the mode in the low two bits
    CSR_MSCRATCH = 12'h340,  // Free scratch word for the handler
    CSR_MEPC     = 12'h341,  // Interrupted pc saved at trap entry
    CSR_MCAUSE   = 12'h342,  // Interrupt flag in bit 31 plus the cause code
    CSR_MIP      = 12'h344   // Pending bits sampled from the interrupt lines
  } csr_addr_e;

  // Low two bits of funct3 select the read-modify-write flavour
  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'b01,  // CSRRW and CSRRWI replace the value
    CSR_OP_SET   = 2'b10,  // CSRRS and CSRRSI OR the operand in
    CSR_OP_CLEAR = 2'b11   // CSRRC and CSRRCI clear the operand bits
  } csr_op_e;

  // Row number inside the CSR storage array
  typedef logic [2:0] csr_idx_t;

  localparam int unsigned CSR_COUNT = 7;  // Number of implemented machine CSRs

  // Storage rows of the CSR array
  localparam csr_idx_t IDX_MCAUSE   = 3'd0;
  localparam csr_idx_t IDX_MTVEC    = 3'd1;
  localparam csr_idx_t IDX_MSCRATCH = 3'd2;
  localparam csr_idx_t IDX_MSTATUS  = 3'd3;
  localparam csr_idx_t IDX_MEPC     = 3'd4;
  localparam csr_idx_t IDX_MIP      = 3'd5;
  localparam csr_idx_t IDX_MIE      = 3'd6;

endpackage

// ==== verilog/rv_intr_pkg.sv ====
package rv_intr_pkg;

  // Interrupt cause codes written into the low bits of mcause
  typedef enum logic [4:0] {
    INTR_MSI = 5'd3,   // Machine software interrupt from msip
    INTR_MTI = 5'd7,   // Machine timer interrupt from the mtime compare
    INTR_MEI = 5'd11   // Machine external interrupt from the ext_irq pin
  } intr_code_e;

  // Registers of the core-local timer block as seen on the APB port
  typedef enum logic [2:0] {
    CLINT_REG_NONE,         // Offset that maps to nothing and errors out
    CLINT_REG_MSIP,         // Software interrupt pending in bit 0
    CLINT_REG_MTIMECMP_LO,  // Compare value bits 31 to 0
    CLINT_REG_MTIMECMP_HI,  // Compare value bits 63 to 32
    CLINT_REG_MTIME_LO,     // Free running counter bits 31 to 0
    CLINT_REG_MTIME_HI      // Free running counter bits 63 to 32
  } clint_reg_e;

  localparam int unsigned CLINT_TIME_W = 64;  // Width of mtime and mtimecmp

endpackage

// ==== verilog/trap_if.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

interface trap_if;
  import rv_intr_pkg::*;

  logic                take;         // Trap entry on the coming edge
  logic                ret;          // mret restore on the coming edge
  intr_code_e          cause;        // Winning interrupt cause
  logic [`RV_XLEN-1:0] epc;          // Pc of the retiring instruction

  logic                mstatus_mie;  // Global machine interrupt enable
  logic [`RV_XLEN-1:0] mie;          // Per source enables
  logic [`RV_XLEN-1:0] mip;          // Sampled pending lines
  logic [`RV_XLEN-1:0] mtvec;        // Vector base and mode
  logic [`RV_XLEN-1:0] mepc;         // Saved return address

  // Arbiter side decides and the CSR side stores
  modport arb (output take, ret, cause, epc,
               input  mstatus_mie, mie, mip, mtvec, mepc);

  modport csr (input  take, ret, cause, epc,
               output mstatus_mie, mie, mip, mtvec, mepc);

endinterface

// ==== verilog/csr_alu.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module csr_alu (
  input  rv_csr_pkg::csr_op_e  csr_op,        // Decoded CSR operation
  input  logic                 csr_imm_sel,   // Operand comes from the zimm field
  input  logic [`RV_XLEN-1:0]  csr_wdata,     // rs1 value or zero extended immediate
  input  logic                 csr_src_zero,  // rs1 index or immediate is zero
  input  logic [`RV_XLEN-1:0]  old_value,     // Current contents of the addressed CSR
  output logic [`RV_XLEN-1:0]  new_value,     // Value to store on the next edge
  output logic                 write_en       // The instruction really writes
);
  import rv_csr_pkg::*;

  logic [`RV_XLEN-1:0] operand;  // Source after immediate masking

  // The zimm field is only five bits wide so the upper bits are forced low
  assign operand = csr_imm_sel ? {{(`RV_XLEN-5){1'b0}}, csr_wdata[4:0]} : csr_wdata;

  always_comb begin
    new_value = old_value;  // Hold the value for unknown encodings
    write_en  = 1'b0;
    case (csr_op)
      CSR_OP_WRITE: begin
        new_value = operand;  // Plain replace always writes
        write_en  = 1'b1;
      end
      CSR_OP_SET: begin
        new_value = old_value | operand;  // Set the requested bits
        write_en  = !csr_src_zero;         // A zero source turns it into a pure read
      end
      CSR_OP_CLEAR: begin
        new_value = old_value & ~operand;  // Clear the requested bits
        write_en  = !csr_src_zero;          // Same read only rule as set
      end
      default: begin
        new_value = old_value;  // Reserved encoding behaves as a read
        write_en  = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module csr_file (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   csr_valid,  // A decoded CSR instruction is present
  input  rv_csr_pkg::csr_addr_e  csr_addr,   // CSR number from the instruction
  input  logic                   write_en,   // The ALU wants to store new_value
  input  logic [`RV_XLEN-1:0]    new_value,  // Value computed by the ALU
  output logic [`RV_XLEN-1:0]    rdata,      // Old CSR value for the register file
  output logic                   illegal,    // Unknown CSR or write to mip
  input  logic                   msip_irq,   // Software interrupt line
  input  logic                   mtip_irq,   // Timer interrupt line
  input  logic                   ext_irq,    // External interrupt line
  trap_if.csr                    trap        // Trap events in and state out
);
  import rv_csr_pkg::*;

  logic [`RV_XLEN-1:0] csr_mem [CSR_COUNT];  // Storage rows indexed by csr_idx_t
  csr_idx_t            idx;                   // Decoded row for the current request
  logic                addr_ok;               // The CSR number is implemented
  logic                wr_fire;               // Legal instruction write this cycle
  logic [`RV_XLEN-1:0] mip_next;              // Interrupt lines placed at their bits

  // Translate the architectural CSR number into a storage row
  always_comb begin
    idx     = IDX_MCAUSE;
    addr_ok = 1'b1;
    case (csr_addr)
      CSR_MCAUSE:   idx = IDX_MCAUSE;
      CSR_MTVEC:    idx = IDX_MTVEC;
      CSR_MSCRATCH: idx = IDX_MSCRATCH;
      CSR_MSTATUS:  idx = IDX_MSTATUS;
      CSR_MEPC:     idx = IDX_MEPC;
      CSR_MIP:      idx = IDX_MIP;
      CSR_MIE:      idx = IDX_MIE;
      default:      addr_ok = 1'b0;  // Anything else is not implemented
    endcase
  end

  // mip is read only so a real write to it is rejected like a bad number
  assign illegal = csr_valid & (~addr_ok | ((csr_addr == CSR_MIP) & write_en));
  assign rdata   = (csr_valid & ~illegal) ? csr_mem[idx] : '0;  // Zero on reject
  assign wr_fire = csr_valid & write_en & ~illegal;

  always_comb begin
    mip_next              = '0;
    mip_next[`RV_MSI_BIT] = msip_irq;  // MSIP
    mip_next[`RV_MTI_BIT] = mtip_irq;  // MTIP
    mip_next[`RV_MEI_BIT] = ext_irq;   // MEIP
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      csr_mem <= '{default: '0};  // Every CSR starts at zero
    end else begin
      if (wr_fire) begin
        csr_mem[idx] <= new_value;  // Instruction write lands on this edge
      end
      // Trap entry and mret come later so their fields override a same cycle write
      if (trap.take) begin
        csr_mem[IDX_MEPC]   <= trap.epc;  // Resume point for mret
        csr_mem[IDX_MCAUSE] <= {1'b1, {(`RV_XLEN-6){1'b0}}, trap.cause};  // Interrupt flag set
        csr_mem[IDX_MSTATUS][`RV_MSTATUS_MPIE_BIT] <= csr_mem[IDX_MSTATUS][`RV_MSTATUS_MIE_BIT];
        csr_mem[IDX_MSTATUS][`RV_MSTATUS_MIE_BIT]  <= 1'b0;  // Handler runs with interrupts off
      end else if (trap.ret) begin
        csr_mem[IDX_MSTATUS][`RV_MSTATUS_MIE_BIT]  <= csr_mem[IDX_MSTATUS][`RV_MSTATUS_MPIE_BIT];
        csr_mem[IDX_MSTATUS][`RV_MSTATUS_MPIE_BIT] <= 1'b0;  // Saved copy is consumed
      end
      csr_mem[IDX_MIP] <= mip_next;  // Lines show up in mip one cycle late
    end
  end

  // State the arbiter needs every cycle
  assign trap.mstatus_mie = csr_mem[IDX_MSTATUS][`RV_MSTATUS_MIE_BIT];
  assign trap.mie         = csr_mem[IDX_MIE];
  assign trap.mip         = csr_mem[IDX_MIP];
  assign trap.mtvec       = csr_mem[IDX_MTVEC];
  assign trap.mepc        = csr_mem[IDX_MEPC];

endmodule

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module clint_timer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     psel,      // APB select
  input  logic                     penable,   // APB access phase
  input  logic                     pwrite,    // APB write strobe
  input  logic [`CLINT_ADDR_W-1:0] paddr,     // Byte offset inside the block
  input  logic [`RV_XLEN-1:0]      pwdata,    // Write data
  output logic [`RV_XLEN-1:0]      prdata,    // Read data
  output logic                     pready,    // Always ready
  output logic                     pslverr,   // Unmapped offset
  output logic                     msip_irq,  // Software interrupt line
  output logic                     mtip_irq   // Timer interrupt line
);
  import rv_intr_pkg::*;

  logic [CLINT_TIME_W-1:0] mtime;      // Free running counter
  logic [CLINT_TIME_W-1:0] mtime_inc;  // Counter plus one
  logic [CLINT_TIME_W-1:0] mtimecmp;   // Compare value
  logic                    msip;       // Software interrupt pending
  clint_reg_e              reg_sel;    // Decoded register for paddr
  logic                    access;     // APB access phase
  logic                    wr_fire;    // Write to a mapped register

  always_comb begin
    case (paddr)
      `CLINT_MSIP_OFS:        reg_sel = CLINT_REG_MSIP;
      `CLINT_MTIMECMP_LO_OFS: reg_sel = CLINT_REG_MTIMECMP_LO;
      `CLINT_MTIMECMP_HI_OFS: reg_sel = CLINT_REG_MTIMECMP_HI;
      `CLINT_MTIME_LO_OFS:    reg_sel = CLINT_REG_MTIME_LO;
      `CLINT_MTIME_HI_OFS:    reg_sel = CLINT_REG_MTIME_HI;
      default:                reg_sel = CLINT_REG_NONE;  // Holes in the map
    endcase
  end

  assign access    = psel & penable;
  assign wr_fire   = access & pwrite & (reg_sel != CLINT_REG_NONE);
  assign pready    = 1'b1;                                // No wait states
  assign pslverr   = access & (reg_sel == CLINT_REG_NONE);
  assign mtime_inc = mtime + 1'b1;

  always_comb begin
    case (reg_sel)
      CLINT_REG_MSIP:        prdata = {{(`RV_XLEN-1){1'b0}}, msip};
      CLINT_REG_MTIMECMP_LO: prdata = mtimecmp[31:0];
      CLINT_REG_MTIMECMP_HI: prdata = mtimecmp[63:32];
      CLINT_REG_MTIME_LO:    prdata = mtime[31:0];
      CLINT_REG_MTIME_HI:    prdata = mtime[63:32];
      default:               prdata = '0;  // Error reads return zero
    endcase
  end

  // A half written by software replaces the count while the other half keeps running
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtime <= '0;
    end else if (wr_fire && reg_sel == CLINT_REG_MTIME_LO) begin
      mtime <= {mtime_inc[63:32], pwdata};
    end else if (wr_fire && reg_sel == CLINT_REG_MTIME_HI) begin
      mtime <= {pwdata, mtime_inc[31:0]};
    end else begin
      mtime <= mtime_inc;  // One tick per clock
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtimecmp <= '1;    // Far future so no timer interrupt after reset
      msip     <= 1'b0;
    end else if (wr_fire) begin
      case (reg_sel)
        CLINT_REG_MSIP:        msip            <= pwdata[0];
        CLINT_REG_MTIMECMP_LO: mtimecmp[31:0]  <= pwdata;
        CLINT_REG_MTIMECMP_HI: mtimecmp[63:32] <= pwdata;
        default:               msip            <= msip;  // mtime handled above
      endcase
    end
  end

  assign mtip_irq = (mtime >= mtimecmp);  // Level stays high until mtimecmp moves up
  assign msip_irq = msip;

endmodule

// ==== verilog/intr_arbiter.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module intr_arbiter (
  input  logic                retire_valid,  // An instruction retires this cycle
  input  logic [`RV_XLEN-1:0] retire_pc,     // Pc of that instruction
  input  logic                mret_valid,    // The retiring instruction is mret
  output logic                trap_taken,    // Redirect fetch to trap_pc
  output logic [`RV_XLEN-1:0] trap_pc,       // Handler entry address
  output logic [`RV_XLEN-1:0] ret_pc,        // Return address for mret
  trap_if.arb                 trap           // CSR state in and trap events out
);
  import rv_intr_pkg::*;

  logic [`RV_XLEN-1:0] active;    // Pending and individually enabled
  logic                any_irq;   // Something could be taken
  logic [`RV_XLEN-1:0] base;      // mtvec with the mode bits cleared
  logic [`RV_XLEN-1:0] vec_ofs;   // Four times the cause
  logic [1:0]          mode;      // mtvec mode field

  assign active  = trap.mie & trap.mip;
  assign any_irq = trap.mstatus_mie &
                   (active[`RV_MEI_BIT] | active[`RV_MSI_BIT] | active[`RV_MTI_BIT]);

  // Fixed priority with external first then software then timer
  always_comb begin
    if (active[`RV_MEI_BIT]) begin
      trap.cause = INTR_MEI;
    end else if (active[`RV_MSI_BIT]) begin
      trap.cause = INTR_MSI;
    end else begin
      trap.cause = INTR_MTI;  // Also the idle value when take is low
    end
  end

  // Interrupts are only taken between instructions
  assign trap.take  = retire_valid & any_irq;
  assign trap.epc   = retire_pc;
  assign trap_taken = trap.take;

  // A trap in the same cycle wins over mret
  assign trap.ret = mret_valid & ~trap.take;

  assign mode    = trap.mtvec[1:0];
  assign base    = {trap.mtvec[`RV_XLEN-1:2], 2'b00};
  assign vec_ofs = {{(`RV_XLEN-7){1'b0}}, trap.cause, 2'b00};

  always_comb begin
    if (mode == 2'b01) begin
      trap_pc = base + vec_ofs;  // Vectored mode jumps into the table
    end else begin
      trap_pc = base;            // Direct mode and reserved modes use the base
    end
  end

  assign ret_pc = trap.mepc;  // mret resumes at the saved pc

endmodule

// ==== verilog/trap_ctrl_top.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module trap_ctrl_top (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     csr_valid,     // Decoded CSR instruction present
  input  rv_csr_pkg::csr_op_e      csr_op,        // Write, set or clear
  input  logic                     csr_imm_sel,   // Immediate form
  input  logic [11:0]              csr_addr,      // Raw CSR number
  input  logic [`RV_XLEN-1:0]      csr_wdata,     // rs1 value or zimm
  input  logic                     csr_src_zero,  // Source index is x0 or zimm is zero
  output logic [`RV_XLEN-1:0]      csr_rdata,     // Old value for rd
  output logic                     csr_illegal,   // Rejected access
  input  logic                     retire_valid,  // Instruction boundary
  input  logic [`RV_XLEN-1:0]      retire_pc,     // Pc of the retiring instruction
  input  logic                     mret_valid,    // Retiring instruction is mret
  output logic                     trap_taken,    // Interrupt taken at this boundary
  output logic [`RV_XLEN-1:0]      trap_pc,       // Handler address
  output logic [`RV_XLEN-1:0]      ret_pc,        // mret target
  input  logic                     ext_irq,       // External interrupt pin
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`CLINT_ADDR_W-1:0] paddr,
  input  logic [`RV_XLEN-1:0]      pwdata,
  output logic [`RV_XLEN-1:0]      prdata,
  output logic                     pready,
  output logic                     pslverr
);
  import rv_csr_pkg::*;

  logic                write_en;   // ALU write request
  logic [`RV_XLEN-1:0] new_value;  // ALU result
  logic                msip_irq;   // Timer block software line
  logic                mtip_irq;   // Timer block compare line

  trap_if u_trap_if ();

  csr_alu u_csr_alu (
    .csr_op(csr_op), .csr_imm_sel(csr_imm_sel), .csr_wdata(csr_wdata),
    .csr_src_zero(csr_src_zero), .old_value(csr_rdata),
    .new_value(new_value), .write_en(write_en)
  );

  csr_file u_csr_file (
    .clk(clk), .reset_n(reset_n), .csr_valid(csr_valid),
    .csr_addr(csr_addr_e'(csr_addr)), .write_en(write_en), .new_value(new_value),
    .rdata(csr_rdata), .illegal(csr_illegal), .msip_irq(msip_irq),
    .mtip_irq(mtip_irq), .ext_irq(ext_irq), .trap(u_trap_if.csr)
  );

  clint_timer u_clint_timer (
    .clk(clk), .reset_n(reset_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .msip_irq(msip_irq), .mtip_irq(mtip_irq)
  );

  intr_arbiter u_intr_arbiter (
    .retire_valid(retire_valid), .retire_pc(retire_pc), .mret_valid(mret_valid),
    .trap_taken(trap_taken), .trap_pc(trap_pc), .ret_pc(ret_pc),
    .trap(u_trap_if.arb)
  );

endmodule

// ==== tests/tb_trap_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_trap_defines.svh"

module tb_trap_ctrl;
  import rv_csr_pkg::*;

  localparam int          TIMEOUT   = 200;                             // Poll limit in cycles
  localparam logic [31:0] MSI_MASK  = 32'h1 << `RV_MSI_BIT;
  localparam logic [31:0] MTI_MASK  = 32'h1 << `RV_MTI_BIT;
  localparam logic [31:0] MEI_MASK  = 32'h1 << `RV_MEI_BIT;
  localparam logic [31:0] MIE_MASK  = 32'h1 << `RV_MSTATUS_MIE_BIT;
  localparam logic [31:0] MPIE_MASK = 32'h1 << `RV_MSTATUS_MPIE_BIT;
  localparam logic [31:0] SOFT_PC   = 32'h0000_2468;                 // Pc interrupted in test 2

  logic                     clk;
  logic                     reset_n;
  logic                     csr_valid;
  csr_op_e                  csr_op;
  logic                     csr_imm_sel;
  logic [11:0]              csr_addr;
  logic [`RV_XLEN-1:0]      csr_wdata;
  logic                     csr_src_zero;
  logic [`RV_XLEN-1:0]      csr_rdata;
  logic                     csr_illegal;
  logic                     retire_valid;
  logic [`RV_XLEN-1:0]      retire_pc;
  logic                     mret_valid;
  logic                     trap_taken;
  logic [`RV_XLEN-1:0]      trap_pc;
  logic [`RV_XLEN-1:0]      ret_pc;
  logic                     ext_irq;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [`CLINT_ADDR_W-1:0] paddr;
  logic [`RV_XLEN-1:0]      pwdata;
  logic [`RV_XLEN-1:0]      prdata;
  logic                     pready;
  logic                     pslverr;
  int                       errors;       // Failed checks over the whole run
  int                       checks;       // Checks executed
  int                       test_start;   // Error count when the current test began

  trap_ctrl_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_start = errors;
  endtask

  task automatic end_test(input string name);
    $display("Test %-14s %s with %0d errors", name,
             (errors == test_start) ? "passed" : "failed", errors - test_start);
  endtask

  // One CSR instruction with the read sampled mid cycle and the write on the closing edge
  task automatic csr_access(input csr_op_e op, input logic imm, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic illegal);
    @(posedge clk);
    csr_valid    <= 1'b1;
    csr_op       <= op;
    csr_imm_sel  <= imm;
    csr_addr     <= addr;
    csr_wdata    <= wdata;
    csr_src_zero <= (wdata == '0);  // Source x0 or zimm zero is modelled as a zero operand
    @(negedge clk);
    rdata   = csr_rdata;
    illegal = csr_illegal;
    @(posedge clk);
    csr_valid <= 1'b0;
  endtask

  task automatic csr_op_check(input csr_op_e op, input logic imm, input logic [11:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata,
                              input logic exp_illegal);
    logic [31:0] got;
    logic        ill;
    csr_access(op, imm, addr, wdata, got, ill);
    check("csr_rdata", got, exp_rdata);
    check("csr_illegal", ill, exp_illegal);
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    logic ill;
    csr_access(CSR_OP_SET, 1'b0, addr, '0, data, ill);  // CSRRS with x0 is a pure read
    check("csr_illegal", ill, 1'b0);
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] old;
    logic        ill;
    csr_access(CSR_OP_WRITE, 1'b0, addr, data, old, ill);
    check("csr_illegal", ill, 1'b0);
  endtask

  task automatic expect_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    csr_read(addr, got);
    check(name, got, exp);
  endtask

  // Setup then access phase with a bounded wait on pready
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!pready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (pready) else begin
      $display("Timeout at %0t ns: APB slave never raised pready", $time);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check("pslverr", err, 1'b0);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check("pslverr", err, 1'b0);
  endtask

  // One retiring instruction with outputs sampled before the edge that commits it
  task automatic retire(input logic [31:0] pc, input logic mret, output logic taken,
                        output logic [31:0] tpc, output logic [31:0] rpc);
    @(posedge clk);
    retire_valid <= 1'b1;
    retire_pc    <= pc;
    mret_valid   <= mret;
    @(negedge clk);
    taken = trap_taken;
    tpc   = trap_pc;
    rpc   = ret_pc;
    @(posedge clk);
    retire_valid <= 1'b0;
    mret_valid   <= 1'b0;
  endtask

  // Poll mip until the masked bits match
  task automatic wait_mip(input logic [31:0] mask, input logic [31:0] exp);
    logic [31:0] v;
    int          n;
    n = 0;
    csr_read(CSR_MIP, v);
    while ((v & mask) != exp && n < TIMEOUT) begin
      csr_read(CSR_MIP, v);
      n++;
    end
    assert ((v & mask) == exp) else begin
      $display("Timeout at %0t ns: mip bits %h never became %h", $time, mask, exp);
      errors++;
    end
  endtask

  task automatic test_csr_access();
    logic [31:0] model;  // Expected mscratch contents
    begin_test();
    csr_op_check(CSR_OP_WRITE, 1'b0, CSR_MSCRATCH, 32'hA5A5_1234, 32'h0, 1'b0);
    model = 32'hA5A5_1234;
    csr_op_check(CSR_OP_WRITE, 1'b0, CSR_MSCRATCH, 32'h0F0F_00F0, model, 1'b0);  // Old value
    model = 32'h0F0F_00F0;
    expect_csr("mscratch", CSR_MSCRATCH, model);
    csr_op_check(CSR_OP_SET, 1'b0, CSR_MSCRATCH, 32'h3000_0001, model, 1'b0);
    model = model | 32'h3000_0001;
    csr_op_check(CSR_OP_CLEAR, 1'b0, CSR_MSCRATCH, 32'h0F00_0000, model, 1'b0);
    model = model & ~32'h0F00_0000;
    csr_op_check(CSR_OP_SET, 1'b1, CSR_MSCRATCH, 32'h0000_001A, model, 1'b0);  // CSRRSI
    model = model | 32'h0000_001A;
    csr_op_check(CSR_OP_CLEAR, 1'b1, CSR_MSCRATCH, 32'h0000_0011, model, 1'b0);  // CSRRCI
    model = model & ~32'h0000_0011;
    expect_csr("mscratch", CSR_MSCRATCH, model);
    csr_op_check(CSR_OP_SET, 1'b0, CSR_MSCRATCH, 32'h0, model, 1'b0);  // Zero source
    expect_csr("mscratch", CSR_MSCRATCH, model);
    csr_op_check(CSR_OP_WRITE, 1'b0, 12'h7C0, 32'hFFFF_FFFF, 32'h0, 1'b1);  // Unknown number
    expect_csr("mcause", CSR_MCAUSE, 32'h0);  // A rejected write stores nothing
    csr_op_check(CSR_OP_WRITE, 1'b0, CSR_MIP, 32'h0000_0888, 32'h0, 1'b1);  // mip is read only
    csr_op_check(CSR_OP_SET, 1'b0, CSR_MIP, 32'h0, 32'h0, 1'b0);  // Reading mip stays legal
    end_test("csr_access");
  endtask

  task automatic test_soft_irq_direct();
    logic        taken;
    logic [31:0] tpc;
    logic [31:0] rpc;
    begin_test();
    csr_write(CSR_MTVEC, 32'h0000_1000);  // Direct mode
    csr_write(CSR_MIE, MSI_MASK);
    csr_write(CSR_MSTATUS, MIE_MASK);
    apb_write(`CLINT_MSIP_OFS, 32'h1);
    retire(SOFT_PC, 1'b0, taken, tpc, rpc);  // First edge of the retire samples mip
    check("trap_taken", taken, 1'b1);
    check("trap_pc", tpc, 32'h0000_1000);
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_0003);
    expect_csr("mepc", CSR_MEPC, SOFT_PC);
    expect_csr("mstatus", CSR_MSTATUS, MPIE_MASK);
    apb_write(`CLINT_MSIP_OFS, 32'h0);  // Handler acknowledges the source
    end_test("soft_direct");
  endtask

  task automatic test_mret();
    logic        taken;
    logic [31:0] tpc;
    logic [31:0] rpc;
    begin_test();
    retire(32'h0000_1040, 1'b1, taken, tpc, rpc);
    check("trap_taken", taken, 1'b0);
    check("ret_pc", rpc, SOFT_PC);
    expect_csr("mstatus", CSR_MSTATUS, MIE_MASK);  // MIE back from MPIE
    end_test("mret");
  endtask

  task automatic test_timer_vectored();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] cmp;
    logic        taken;
    logic [31:0] tpc;
    int          n;
    begin_test();
    csr_write(CSR_MTVEC, 32'h0000_2001);  // Vectored mode
    csr_write(CSR_MIE, MTI_MASK);
    csr_write(CSR_MSTATUS, MIE_MASK);
    apb_read(`CLINT_MTIME_LO_OFS, lo);
    apb_read(`CLINT_MTIME_HI_OFS, hi);
    cmp = {hi, lo} + 64'd20;
    apb_write(`CLINT_MTIMECMP_LO_OFS, cmp[31:0]);  // High half is still all ones here
    apb_write(`CLINT_MTIMECMP_HI_OFS, cmp[63:32]);
    @(posedge clk);
    retire_valid <= 1'b1;
    retire_pc    <= 32'h0000_3000;
    n = 0;
    @(negedge clk);
    while (!trap_taken && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    taken = trap_taken;
    tpc   = trap_pc;
    @(posedge clk);
    retire_valid <= 1'b0;
    assert (taken) else begin
      $display("Timeout at %0t ns: timer interrupt was never taken", $time);
      errors++;
    end
    assert (n >= 4) else begin
      $display("Timer interrupt was taken before mtime could reach mtimecmp");
      errors++;
    end
    check("trap_pc", tpc, 32'h0000_2000 + 32'd4 * 32'd7);
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_0007);
    apb_write(`CLINT_MTIMECMP_LO_OFS, 32'hFFFF_FFFF);
    apb_write(`CLINT_MTIMECMP_HI_OFS, 32'hFFFF_FFFF);
    wait_mip(MTI_MASK, 32'h0);  // MTIP drops once the compare moves away
    end_test("timer_vector");
  endtask

  task automatic test_priority();
    logic        taken;
    logic [31:0] tpc;
    logic [31:0] rpc;
    begin_test();
    csr_write(CSR_MIE, MSI_MASK | MTI_MASK | MEI_MASK);
    csr_write(CSR_MSTATUS, MIE_MASK);
    @(posedge clk);
    ext_irq <= 1'b1;
    apb_write(`CLINT_MSIP_OFS, 32'h1);
    wait_mip(MSI_MASK | MEI_MASK, MSI_MASK | MEI_MASK);
    retire(32'h0000_4000, 1'b0, taken, tpc, rpc);
    check("trap_taken", taken, 1'b1);
    check("trap_pc", tpc, 32'h0000_2000 + 32'd4 * 32'd11);  // External wins
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_000B);
    csr_write(CSR_MIE, MSI_MASK | MTI_MASK);  // Mask external
    csr_write(CSR_MSTATUS, MIE_MASK);
    retire(32'h0000_4004, 1'b0, taken, tpc, rpc);
    check("trap_taken", taken, 1'b1);
    check("trap_pc", tpc, 32'h0000_2000 + 32'd4 * 32'd3);
    expect_csr("mcause", CSR_MCAUSE, 32'h8000_0003);
    csr_write(CSR_MIE, MSI_MASK | MTI_MASK | MEI_MASK);
    csr_write(CSR_MSTATUS, 32'h0);  // Global enable off
    retire(32'h0000_4008, 1'b0, taken, tpc, rpc);
    check("trap_taken", taken, 1'b0);
    @(posedge clk);
    ext_irq <= 1'b0;
    apb_write(`CLINT_MSIP_OFS, 32'h0);
    end_test("priority");
  endtask

  task automatic test_apb_map();
    logic [31:0] data;
    logic        err;
    begin_test();
    apb_write(`CLINT_MTIMECMP_LO_OFS, 32'h1234_5678);
    apb_write(`CLINT_MTIMECMP_HI_OFS, 32'h9ABC_DEF0);
    apb_read(`CLINT_MTIMECMP_LO_OFS, data);
    check("prdata", data, 32'h1234_5678);
    apb_read(`CLINT_MTIMECMP_HI_OFS, data);
    check("prdata", data, 32'h9ABC_DEF0);
    apb_write(`CLINT_MSIP_OFS, 32'h1);
    apb_read(`CLINT_MSIP_OFS, data);
    check("prdata", data, 32'h1);
    wait_mip(MSI_MASK, MSI_MASK);  // msip reaches mip
    apb_write(`CLINT_MSIP_OFS, 32'h0);
    wait_mip(MSI_MASK, 32'h0);
    apb_access(1'b0, 8'h20, 32'h0, data, err);  // Unmapped offset answers at once with an error
    check("pslverr", err, 1'b1);
    apb_access(1'b1, 8'h20, 32'h5A5A_5A5A, data, err);
    check("pslverr", err, 1'b1);
    end_test("apb_map");
  endtask

  initial begin
    reset_n      = 1'b0;
    csr_valid    = 1'b0;
    csr_op       = CSR_OP_WRITE;
    csr_imm_sel  = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    csr_src_zero = 1'b0;
    retire_valid = 1'b0;
    retire_pc    = '0;
    mret_valid   = 1'b0;
    ext_irq      = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    errors       = 0;
    checks       = 0;
    test_start   = 0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    test_csr_access();
    test_soft_irq_direct();
    test_mret();
    test_timer_vectored();
    test_priority();
    test_apb_map();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== trap_ctrl.f ====
+incdir+verilog
verilog/rv_csr_pkg.sv
verilog/rv_intr_pkg.sv
verilog/trap_if.sv
verilog/csr_alu.sv
verilog/csr_file.sv
verilog/clint_timer.sv
verilog/intr_arbiter.sv
verilog/trap_ctrl_top.sv
tests/tb_trap_ctrl.sv

// ==== Bender.yml ====
package:
  name: trap_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_csr_pkg.sv
      - verilog/rv_intr_pkg.sv
      - verilog/trap_if.sv
      - verilog/csr_alu.sv
      - verilog/csr_file.sv
      - verilog/clint_timer.sv
      - verilog/intr_arbiter.sv
      - verilog/trap_ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_trap_ctrl.sv
